// File: hdl/cache_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_rd_if import cache_pkg::*; ();
    logic  req;    // level held until gnt
    addr_t addr;
    logic  line;   // 1 for a full line burst
    logic  gnt;
    word_t data;
    logic  valid;
    logic  last;

    modport client (output req, addr, line, input gnt, data, valid, last);
    modport server (input req, addr, line, output gnt, data, valid, last);
endinterface

interface mem_wr_if import cache_pkg::*; ();
    logic  push;
    addr_t addr;
    word_t data;
    sel_t  sel;
    logic  full;
    logic  empty;  // includes the write in flight

    modport client (output push, addr, data, sel, input full, empty);
    modport server (input push, addr, data, sel, output full, empty);
endinterface

`default_nettype wire

// File: hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int LINE_WORDS  = 4;
    localparam int CACHE_LINES = 16;
    localparam int WBUF_DEPTH  = 4;

    localparam int OFFSET_W   = $clog2(LINE_WORDS);  // word within line
    localparam int INDEX_W    = $clog2(CACHE_LINES);
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W - 2;
    localparam int WBUF_PTR_W = $clog2(WBUF_DEPTH);

    typedef logic [31:0]         word_t;
    typedef logic [31:0]         addr_t;
    typedef logic [3:0]          sel_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [7:0]          beat_t;

    typedef enum logic [1:0] {
        CS_IDLE,
        CS_LOOKUP,
        CS_REFILL,
        CS_DONE
    } cache_state_t;

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

    typedef enum logic [1:0] {WR_IDLE, WR_SEND, WR_RESP} wr_state_t;

endpackage

`default_nettype wire

// File: hdl/cache_soc.sv
`timescale 1ns/1ps
`default_nettype none

module cache_soc import cache_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_ib_cyc,
    input  logic  i_ib_stb,
    input  addr_t i_ib_adr,
    output word_t o_ib_dat,
    output logic  o_ib_ack,
    input  logic  i_db_cyc,
    input  logic  i_db_stb,
    input  logic  i_db_we,
    input  sel_t  i_db_sel,
    input  addr_t i_db_adr,
    input  word_t i_db_dat,
    output word_t o_db_dat,
    output logic  o_db_ack,
    output addr_t o_araddr,
    output beat_t o_arlen,
    output logic  o_arvalid,
    input  logic  i_arready,
    input  word_t i_rdata,
    input  logic  i_rlast,
    input  logic  i_rvalid,
    output logic  o_rready,
    output addr_t o_awaddr,
    output logic  o_awvalid,
    input  logic  i_awready,
    output word_t o_wdata,
    output sel_t  o_wstrb,
    output logic  o_wvalid,
    input  logic  i_wready,
    input  logic  i_bvalid,
    output logic  o_bready
);

    mem_rd_if irq_if ();
    mem_rd_if drq_if ();
    mem_wr_if wbuf_if ();

    icache u_icache (
        .i_clk, .i_rst,
        .i_cyc (i_ib_cyc),
        .i_stb (i_ib_stb),
        .i_adr (i_ib_adr),
        .o_dat (o_ib_dat),
        .o_ack (o_ib_ack),
        .rd    (irq_if)
    );

    dcache u_dcache (
        .i_clk, .i_rst,
        .i_cyc (i_db_cyc),
        .i_stb (i_db_stb),
        .i_we  (i_db_we),
        .i_sel (i_db_sel),
        .i_adr (i_db_adr),
        .i_dat (i_db_dat),
        .o_dat (o_db_dat),
        .o_ack (o_db_ack),
        .rd    (drq_if),
        .wr    (wbuf_if)
    );

    mem_read u_mem_read (
        .i_clk, .i_rst,
        .irq (irq_if),
        .drq (drq_if),
        .o_araddr, .o_arlen, .o_arvalid, .i_arready,
        .i_rdata, .i_rlast, .i_rvalid, .o_rready
    );

    mem_write u_mem_write (
        .i_clk, .i_rst,
        .wr (wbuf_if),
        .o_awaddr, .o_awvalid, .i_awready,
        .o_wdata, .o_wstrb, .o_wvalid, .i_wready,
        .i_bvalid, .o_bready
    );

endmodule

`default_nettype wire

// File: hdl/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache import cache_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_cyc,
    input  logic      i_stb,
    input  logic      i_we,
    input  sel_t      i_sel,
    input  addr_t     i_adr,
    input  word_t     i_dat,
    output word_t     o_dat,
    output logic      o_ack,
    mem_rd_if.client  rd,
    mem_wr_if.client  wr
);

    tag_t                   tags [CACHE_LINES];
    word_t                  lines [CACHE_LINES][LINE_WORDS];
    logic [CACHE_LINES-1:0] valid;
    cache_state_t           state;
    offset_t                beat;
    logic                   req_sent;
    tag_t                   tag;
    index_t                 idx;
    offset_t                off;
    logic                   uncached;
    logic                   hit;

    assign tag      = i_adr[31 -: TAG_W];
    assign idx      = i_adr[OFFSET_W+2 +: INDEX_W];
    assign off      = i_adr[2 +: OFFSET_W];
    assign uncached = i_adr[31];
    assign hit      = !uncached && valid[idx] && (tags[idx] == tag);

    // reads to memory stay behind every buffered store
    assign rd.req  = (state == CS_REFILL) && !req_sent && wr.empty;
    assign rd.addr = {i_adr[31:2], 2'b00};
    assign rd.line = !uncached;

    assign wr.push = (state == CS_LOOKUP) && i_we && !wr.full;
    assign wr.addr = {i_adr[31:2], 2'b00};
    assign wr.data = i_dat;
    assign wr.sel  = i_sel;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= CS_IDLE;
            o_ack    <= 1'b0;
            req_sent <= 1'b0;
            beat     <= '0;
            valid    <= '0;
        end else begin
            o_ack <= 1'b0;
            case (state)
                CS_IDLE: if (i_cyc && i_stb) state <= CS_LOOKUP;
                CS_LOOKUP: begin
                    if (i_we) begin
                        if (!wr.full) begin  // store taken this cycle
                            o_ack <= 1'b1;
                            state <= CS_DONE;
                        end
                    end else if (hit) begin
                        o_ack <= 1'b1;
                        state <= CS_DONE;
                    end else begin
                        state    <= CS_REFILL;
                        req_sent <= 1'b0;
                        beat     <= '0;
                    end
                end
                CS_REFILL: begin
                    if (rd.gnt) req_sent <= 1'b1;
                    if (rd.valid) begin
                        beat <= beat + 1'b1;
                        if (rd.last) begin
                            o_ack <= 1'b1;
                            state <= CS_DONE;
                            if (!uncached) valid[idx] <= 1'b1;
                        end
                    end
                end
                default: state <= CS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == CS_LOOKUP && !i_we && hit) o_dat <= lines[idx][off];
        if (wr.push && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (i_sel[b]) lines[idx][off][8*b +: 8] <= i_dat[8*b +: 8];  // lane merge
            end
        end
        if (state == CS_REFILL && rd.valid) begin
            if (!uncached) lines[idx][beat] <= rd.data;
            if (uncached || beat == off) o_dat <= rd.data;
            if (rd.last && !uncached) tags[idx] <= tag;
        end
    end

endmodule

`default_nettype wire

// File: hdl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache import cache_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_cyc,
    input  logic      i_stb,
    input  addr_t     i_adr,
    output word_t     o_dat,
    output logic      o_ack,
    mem_rd_if.client  rd
);

    tag_t                   tags [CACHE_LINES];
    word_t                  lines [CACHE_LINES][LINE_WORDS];
    logic [CACHE_LINES-1:0] valid;
    cache_state_t           state;
    offset_t                beat;      // next refill word
    logic                   req_sent;
    tag_t                   tag;
    index_t                 idx;
    offset_t                off;
    logic                   uncached;
    logic                   hit;

    assign tag      = i_adr[31 -: TAG_W];
    assign idx      = i_adr[OFFSET_W+2 +: INDEX_W];
    assign off      = i_adr[2 +: OFFSET_W];
    assign uncached = i_adr[31];
    assign hit      = !uncached && valid[idx] && (tags[idx] == tag);

    assign rd.req  = (state == CS_REFILL) && !req_sent;
    assign rd.addr = {i_adr[31:2], 2'b00};
    assign rd.line = !uncached;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= CS_IDLE;
            o_ack    <= 1'b0;
            req_sent <= 1'b0;
            beat     <= '0;
            valid    <= '0;
        end else begin
            o_ack <= 1'b0;
            case (state)
                CS_IDLE: if (i_cyc && i_stb) state <= CS_LOOKUP;
                CS_LOOKUP: begin
                    if (hit) begin
                        o_ack <= 1'b1;
                        state <= CS_DONE;
                    end else begin
                        state    <= CS_REFILL;
                        req_sent <= 1'b0;
                        beat     <= '0;
                    end
                end
                CS_REFILL: begin
                    if (rd.gnt) req_sent <= 1'b1;
                    if (rd.valid) begin
                        beat <= beat + 1'b1;
                        if (rd.last) begin
                            o_ack <= 1'b1;
                            state <= CS_DONE;
                            if (!uncached) valid[idx] <= 1'b1;
                        end
                    end
                end
                default: state <= CS_IDLE;  // master drops stb during DONE
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == CS_LOOKUP && hit) o_dat <= lines[idx][off];
        if (state == CS_REFILL && rd.valid) begin
            if (!uncached) lines[idx][beat] <= rd.data;
            if (uncached || beat == off) o_dat <= rd.data;  // keep requested word
            if (rd.last && !uncached) tags[idx] <= tag;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_read.sv
`timescale 1ns/1ps
`default_nettype none

module mem_read import cache_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    mem_rd_if.server  irq,
    mem_rd_if.server  drq,
    output addr_t     o_araddr,
    output beat_t     o_arlen,
    output logic      o_arvalid,
    input  logic      i_arready,
    input  word_t     i_rdata,
    input  logic      i_rlast,
    input  logic      i_rvalid,
    output logic      o_rready
);

    rd_state_t state;
    logic      owner_d;    // data side owns the bus
    addr_t     pick_addr;
    logic      pick_line;

    // data side first
    assign pick_addr = drq.req ? drq.addr : irq.addr;
    assign pick_line = drq.req ? drq.line : irq.line;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= RD_IDLE;
            owner_d <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (drq.req || irq.req) begin
                        state   <= RD_ADDR;
                        owner_d <= drq.req;
                    end
                end
                RD_ADDR: if (i_arready) state <= RD_DATA;
                RD_DATA: if (i_rvalid && i_rlast) state <= RD_IDLE;
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RD_IDLE) begin
            o_araddr <= pick_line ? {pick_addr[31:OFFSET_W+2], {(OFFSET_W+2){1'b0}}}
                                  : pick_addr;
            o_arlen  <= pick_line ? beat_t'(LINE_WORDS - 1) : '0;
        end
    end

    assign o_arvalid = (state == RD_ADDR);
    assign o_rready  = (state == RD_DATA);

    assign drq.gnt   = o_arvalid && i_arready && owner_d;
    assign irq.gnt   = o_arvalid && i_arready && !owner_d;
    assign drq.valid = o_rready && i_rvalid && owner_d;
    assign irq.valid = o_rready && i_rvalid && !owner_d;
    assign drq.data  = i_rdata;
    assign irq.data  = i_rdata;
    assign drq.last  = i_rlast;
    assign irq.last  = i_rlast;

endmodule

`default_nettype wire

// File: hdl/mem_write.sv
`timescale 1ns/1ps
`default_nettype none

module mem_write import cache_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    mem_wr_if.server  wr,
    output addr_t     o_awaddr,
    output logic      o_awvalid,
    input  logic      i_awready,
    output word_t     o_wdata,
    output sel_t      o_wstrb,
    output logic      o_wvalid,
    input  logic      i_wready,
    input  logic      i_bvalid,
    output logic      o_bready
);

    addr_t                 buf_addr [WBUF_DEPTH];
    word_t                 buf_data [WBUF_DEPTH];
    sel_t                  buf_sel  [WBUF_DEPTH];
    logic [WBUF_PTR_W-1:0] wr_ptr;
    logic [WBUF_PTR_W-1:0] rd_ptr;
    logic [WBUF_PTR_W:0]   count;     // head stays counted until bresp
    wr_state_t             state;
    logic                  aw_done;
    logic                  w_done;
    logic                  push_ok;
    logic                  pop;

    assign wr.full  = (count == (WBUF_PTR_W+1)'(WBUF_DEPTH));
    assign wr.empty = (count == '0);
    assign push_ok  = wr.push && !wr.full;
    assign pop      = (state == WR_RESP) && i_bvalid;

    always_ff @(posedge i_clk) begin
        if (push_ok) begin
            buf_addr[wr_ptr] <= wr.addr;
            buf_data[wr_ptr] <= wr.data;
            buf_sel[wr_ptr]  <= wr.sel;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            state   <= WR_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            if (push_ok) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push_ok && !pop) count <= count + 1'b1;
            else if (pop && !push_ok) count <= count - 1'b1;
            case (state)
                WR_IDLE: begin
                    if (count != '0) begin
                        state   <= WR_SEND;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                WR_SEND: begin
                    if (i_awready) aw_done <= 1'b1;
                    if (i_wready) w_done <= 1'b1;
                    if ((aw_done || i_awready) && (w_done || i_wready)) state <= WR_RESP;
                end
                WR_RESP: if (i_bvalid) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    assign o_awaddr  = buf_addr[rd_ptr];  // head entry
    assign o_wdata   = buf_data[rd_ptr];
    assign o_wstrb   = buf_sel[rd_ptr];
    assign o_awvalid = (state == WR_SEND) && !aw_done;
    assign o_wvalid  = (state == WR_SEND) && !w_done;
    assign o_bready  = (state == WR_RESP);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the cache_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module cache_soc_tb -o sim_cache_soc
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_cache_soc > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: src.f
hdl/cache_pkg.sv
hdl/cache_if.sv
hdl/icache.sv
hdl/dcache.sv
hdl/mem_read.sv
hdl/mem_write.sv
hdl/cache_soc.sv
test/tb_clkgen.sv
test/cache_soc_tb.sv

// File: test/cache_soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_soc_tb import cache_pkg::*; ();

    typedef struct packed {
        logic  port;    // 0 instruction, 1 data
        logic  we;
        addr_t addr;
        sel_t  sel;
        word_t data;
        beat_t ar_new;  // read address handshakes this row adds
    } row_t;

    logic  clk, rst;
    logic  ib_cyc, ib_stb, ib_ack, db_cyc, db_stb, db_we, db_ack;
    addr_t ib_adr, db_adr;
    word_t ib_rdat, db_wdat, db_rdat;
    sel_t  db_sel;
    addr_t araddr, awaddr;
    beat_t arlen;
    logic  arvalid, arready, rlast, rvalid, rready;
    logic  awvalid, awready, wvalid, wready, bvalid, bready;
    word_t rdata, wdata;
    sel_t  wstrb;

    row_t        rows[$];
    logic        table_ready = 1'b0;
    integer      seed = 32'h34b6;
    word_t       mem [logic [28:0]];      // memory model contents
    word_t       ref_mem [logic [28:0]];  // expected contents
    int unsigned ar_count = 0;
    int          ar_wait, aw_wait, w_wait, r_wait;
    int          rd_left = 0;
    addr_t       rd_addr, wr_addr;
    word_t       wr_data;
    sel_t        wr_strb;
    logic        aw_got = 1'b0;
    logic        w_got = 1'b0;

    tb_clkgen u_clkgen (.o_clk(clk), .o_rst(rst));

    cache_soc dut (
        .i_clk(clk), .i_rst(rst),
        .i_ib_cyc(ib_cyc), .i_ib_stb(ib_stb), .i_ib_adr(ib_adr),
        .o_ib_dat(ib_rdat), .o_ib_ack(ib_ack),
        .i_db_cyc(db_cyc), .i_db_stb(db_stb), .i_db_we(db_we), .i_db_sel(db_sel),
        .i_db_adr(db_adr), .i_db_dat(db_wdat), .o_db_dat(db_rdat), .o_db_ack(db_ack),
        .o_araddr(araddr), .o_arlen(arlen), .o_arvalid(arvalid), .i_arready(arready),
        .i_rdata(rdata), .i_rlast(rlast), .i_rvalid(rvalid), .o_rready(rready),
        .o_awaddr(awaddr), .o_awvalid(awvalid), .i_awready(awready),
        .o_wdata(wdata), .o_wstrb(wstrb), .o_wvalid(wvalid), .i_wready(wready),
        .i_bvalid(bvalid), .o_bready(bready)
    );

    function automatic int rand_delay();
        return $random(seed) & 3;  // 0 to 3 cycles
    endfunction

    // memory ignores the top address bit since it only picks the uncached path
    function automatic word_t fill_word(input addr_t a);
        return {3'b000, a[30:2]} ^ 32'h5a5a0000;
    endfunction

    function automatic word_t merge_lanes(input word_t old, input word_t nw, input sel_t sel);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = nw[8*b +: 8];
        end
        return res;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return mem.exists(a[30:2]) ? mem[a[30:2]] : fill_word(a);
    endfunction

    function automatic word_t ref_word(input addr_t a);
        return ref_mem.exists(a[30:2]) ? ref_mem[a[30:2]] : fill_word(a);
    endfunction

    task automatic add_row(input logic port, input logic we, input addr_t addr,
                           input sel_t sel, input word_t data, input beat_t ar_new);
        rows.push_back('{port, we, addr, sel, data, ar_new});
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input beat_t got, input beat_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // one Wishbone classic cycle held until ack
    task automatic wb_access(input row_t r, output word_t got);
        @(posedge clk);
        #1;
        if (r.port) begin
            db_cyc  = 1'b1;
            db_stb  = 1'b1;
            db_we   = r.we;
            db_sel  = r.sel;
            db_adr  = r.addr;
            db_wdat = r.data;
        end else begin
            ib_cyc = 1'b1;
            ib_stb = 1'b1;
            ib_adr = r.addr;
        end
        do @(negedge clk); while (!(r.port ? db_ack : ib_ack));
        got = r.port ? db_rdat : ib_rdat;
        @(posedge clk);
        #1;
        ib_cyc = 1'b0;
        ib_stb = 1'b0;
        db_cyc = 1'b0;
        db_stb = 1'b0;
        db_we  = 1'b0;
    endtask

    // AXI slave samples at negedge and answers 1 ns after the rising edge
    initial begin : axi_memory
        logic ar_fire, r_fire, aw_fire, w_fire, b_fire;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rlast   = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        ar_wait = rand_delay();
        aw_wait = rand_delay();
        w_wait  = rand_delay();
        r_wait  = rand_delay();
        forever begin
            @(negedge clk);
            ar_fire = arvalid && arready;
            r_fire  = rready && rvalid;
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            b_fire  = bready && bvalid;
            if (ar_fire) begin
                ar_count++;
                rd_addr = araddr;
                rd_left = int'(arlen) + 1;
            end
            if (r_fire) begin
                rd_addr += 4;
                rd_left--;
            end
            if (aw_fire) wr_addr = awaddr;
            if (w_fire) begin
                wr_data = wdata;
                wr_strb = wstrb;
            end
            @(posedge clk);
            #1;
            if (ar_fire) begin
                arready = 1'b0;
                ar_wait = rand_delay();
            end
            if (aw_fire) begin
                awready = 1'b0;
                aw_wait = rand_delay();
                aw_got  = 1'b1;
            end
            if (w_fire) begin
                wready = 1'b0;
                w_wait = rand_delay();
                w_got  = 1'b1;
            end
            if (r_fire) begin
                rvalid = 1'b0;
                r_wait = rand_delay();
            end
            if (b_fire) bvalid = 1'b0;
            if (aw_got && w_got) begin  // write lands before its response
                mem[wr_addr[30:2]] = merge_lanes(mem_word(wr_addr), wr_data, wr_strb);
                bvalid = 1'b1;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
            if (arvalid && !arready) begin
                if (ar_wait == 0) arready = 1'b1;
                else ar_wait--;
            end
            if (awvalid && !awready) begin
                if (aw_wait == 0) awready = 1'b1;
                else aw_wait--;
            end
            if (wvalid && !wready) begin
                if (w_wait == 0) wready = 1'b1;
                else w_wait--;
            end
            if (rd_left > 0 && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid = 1'b1;
                    rdata  = mem_word(rd_addr);
                    rlast  = (rd_left == 1);
                end else begin
                    r_wait--;
                end
            end
        end
    end

    initial begin : watchdog
        wait (table_ready);
        repeat (rows.size() * 200) @(posedge clk);
        $display("timeout: the table did not finish within %0d cycles", rows.size() * 200);
        $display("STATUS: FAIL");
        $fatal(1);
    end

    initial begin : stimulus
        row_t        r;
        word_t       got;
        int unsigned ar_before;
        ib_cyc  = 1'b0;
        ib_stb  = 1'b0;
        ib_adr  = '0;
        db_cyc  = 1'b0;
        db_stb  = 1'b0;
        db_we   = 1'b0;
        db_sel  = '0;
        db_adr  = '0;
        db_wdat = '0;
        // port we addr sel data ar_new
        add_row(1'b0, 1'b0, 32'h0000_1008, 4'hf, 32'h0, 8'd1);  // icache line refill
        add_row(1'b0, 1'b0, 32'h0000_1000, 4'hf, 32'h0, 8'd0);
        add_row(1'b0, 1'b0, 32'h0000_1004, 4'hf, 32'h0, 8'd0);
        add_row(1'b0, 1'b0, 32'h0000_100c, 4'hf, 32'h0, 8'd0);
        add_row(1'b0, 1'b0, 32'h8000_2000, 4'hf, 32'h0, 8'd1);  // uncached
        add_row(1'b1, 1'b0, 32'h8000_2004, 4'hf, 32'h0, 8'd1);
        add_row(1'b0, 1'b0, 32'h8000_2000, 4'hf, 32'h0, 8'd1);
        add_row(1'b1, 1'b0, 32'h8000_2004, 4'hf, 32'h0, 8'd1);
        add_row(1'b1, 1'b0, 32'h0000_3004, 4'hf, 32'h0, 8'd1);  // lane merge on a hit
        add_row(1'b1, 1'b1, 32'h0000_3004, 4'b0110, 32'h1122_3344, 8'd0);
        add_row(1'b1, 1'b0, 32'h0000_3004, 4'hf, 32'h0, 8'd0);
        add_row(1'b1, 1'b1, 32'h0000_4008, 4'hf, 32'hdead_beef, 8'd0);
        add_row(1'b1, 1'b0, 32'h8000_4008, 4'hf, 32'h0, 8'd1);
        add_row(1'b1, 1'b1, 32'h0000_5000, 4'hf, 32'h0bad_f00d, 8'd0);  // more writes than entries
        add_row(1'b1, 1'b1, 32'h0000_5004, 4'hf, 32'h1234_5678, 8'd0);
        add_row(1'b1, 1'b1, 32'h0000_5010, 4'hf, 32'hcafe_0001, 8'd0);
        add_row(1'b1, 1'b1, 32'h0000_5000, 4'b0011, 32'h0000_aa55, 8'd0);
        add_row(1'b1, 1'b1, 32'h0000_5020, 4'hf, 32'h7777_8888, 8'd0);
        add_row(1'b1, 1'b1, 32'h0000_5004, 4'b1100, 32'h9abc_0000, 8'd0);
        add_row(1'b1, 1'b0, 32'h0000_5000, 4'hf, 32'h0, 8'd1);
        add_row(1'b1, 1'b0, 32'h0000_5004, 4'hf, 32'h0, 8'd0);
        add_row(1'b1, 1'b0, 32'h0000_5010, 4'hf, 32'h0, 8'd1);
        add_row(1'b1, 1'b0, 32'h0000_5020, 4'hf, 32'h0, 8'd1);
        add_row(1'b0, 1'b0, 32'h0000_6000, 4'hf, 32'h0, 8'd1);  // alternating misses
        add_row(1'b1, 1'b0, 32'h0000_7004, 4'hf, 32'h0, 8'd1);
        add_row(1'b0, 1'b0, 32'h0000_6040, 4'hf, 32'h0, 8'd1);
        add_row(1'b1, 1'b0, 32'h0000_7048, 4'hf, 32'h0, 8'd1);
        add_row(1'b0, 1'b0, 32'h0000_6004, 4'hf, 32'h0, 8'd0);
        add_row(1'b1, 1'b0, 32'h0000_7000, 4'hf, 32'h0, 8'd0);
        table_ready = 1'b1;
        wait (!rst);
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            ar_before = ar_count;
            wb_access(r, got);
            if (r.we) begin
                ref_mem[r.addr[30:2]] = merge_lanes(ref_word(r.addr), r.data, r.sel);
            end else begin
                check_word(r.port ? "o_db_dat" : "o_ib_dat", got, ref_word(r.addr));
            end
            check_count("read address handshakes", beat_t'(ar_count - ar_before), r.ar_new);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;  // 10 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clk);
        #1 o_rst = 1'b0;
    end

endmodule

`default_nettype wire
